// File: all.f
+incdir+.
regfile_pkg.sv
tag_pkg.sv
gpr_slot.sv
gpr_bank.sv
mmx_slot.sv
mmx_bank.sv
regfile.sv
tb_regfile.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module tb_regfile \
    -o tb_regfile_sim \
    && ./obj_dir/tb_regfile_sim | tee sim.log \
    || { echo "Build or run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
    && echo "Result: pass" && exit 0 \
    || { echo "Result: fail"; exit 1; }

// File: tb_regfile_model.svh
`ifndef TB_REGFILE_MODEL_SVH
`define TB_REGFILE_MODEL_SVH

// Expected state per section with index 2 for E, 1 for H and 0 for L
logic [E_W-1:0]    m_e [NUM_GPR];
logic [BYTE_W-1:0] m_h [NUM_GPR];
logic [BYTE_W-1:0] m_l [NUM_GPR];
logic [2:0]        m_valid [NUM_GPR];
tag_id_t           m_id [NUM_GPR][3];
logic [MMX_W-1:0]  m_mmx [8];
logic              m_mmx_valid [8];
tag_id_t           m_mmx_id [8];

function automatic void clear_model();
    for (int r = 0; r < 8; r++) begin
        m_e[r] = '0;
        m_h[r] = '0;
        m_l[r] = '0;
        m_valid[r] = '0;
        m_mmx[r] = '0;
        m_mmx_valid[r] = 1'b0;
        m_mmx_id[r] = '0;
        for (int s = 0; s < 3; s++) begin
            m_id[r][s] = '0;
        end
    end
endfunction

// AH, CH, DH, BH live in registers 0-3
function automatic int target_reg(reg_addr_t addr, op_size_t size);
    if (size == size_8 && addr >= 3'd4) return int'(addr) - 4;
    return int'(addr);
endfunction

function automatic logic [2:0] section_bits(reg_addr_t addr, op_size_t size);
    case (size)
        size_32: return 3'b111;
        size_16: return 3'b011;
        size_8:  return (addr >= 3'd4) ? 3'b010 : 3'b001;
        default: return 3'b000;
    endcase
endfunction

function automatic void mirror_write(reg_addr_t addr, op_size_t size, logic [MMX_W-1:0] data);
    int r;
    r = target_reg(addr, size);
    case (size)
        size_64: m_mmx[addr] = data;
        size_32: begin
            m_e[r] = data[31:16];
            m_h[r] = data[15:8];
            m_l[r] = data[7:0];
        end
        size_16: begin
            m_h[r] = data[15:8];
            m_l[r] = data[7:0];
        end
        default: begin
            if (addr >= 3'd4) m_h[r] = data[7:0];   // Byte value always in the low lane
            else m_l[r] = data[7:0];
        end
    endcase
endfunction

function automatic void reserve_tags(reg_addr_t addr, op_size_t size, tag_id_t id);
    int r;
    logic [2:0] sec;
    if (size == size_64) begin
        m_mmx_valid[addr] = 1'b1;
        m_mmx_id[addr] = id;
        return;
    end
    r = target_reg(addr, size);
    sec = section_bits(addr, size);
    for (int s = 0; s < 3; s++) begin
        if (sec[s]) begin
            m_valid[r][s] = 1'b1;
            m_id[r][s] = id;
        end
    end
endfunction

function automatic void retire_tag(tag_id_t tag);
    for (int r = 0; r < 8; r++) begin
        for (int s = 0; s < 3; s++) begin
            if (m_valid[r][s] && m_id[r][s] == tag) m_valid[r][s] = 1'b0;
        end
        if (m_mmx_valid[r] && m_mmx_id[r] == tag) m_mmx_valid[r] = 1'b0;
    end
endfunction

function automatic logic [MMX_W-1:0] predict_data(reg_addr_t addr, op_size_t size);
    int r;
    logic [GPR_W-1:0] word;
    logic [7:0] b;
    r = target_reg(addr, size);
    word = {m_e[r], m_h[r], m_l[r]};
    case (size)
        size_64: return m_mmx[addr];
        size_32: return {{32{word[31]}}, word};
        size_16: return {{48{word[15]}}, word[15:0]};
        default: begin
            b = (addr >= 3'd4) ? m_h[r] : m_l[r];
            return {{56{b[7]}}, b};
        end
    endcase
endfunction

function automatic logic covers_pending(reg_addr_t addr, op_size_t size);
    if (size == size_64) return m_mmx_valid[addr];
    return |(m_valid[target_reg(addr, size)] & section_bits(addr, size));
endfunction

`endif

// File: tb_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module tb_regfile;
    import regfile_pkg::*;
    import tag_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RAND_CYCLES = 400;

    logic             clk;
    logic             rst_n;
    logic             wr_en;
    reg_addr_t        wr_addr;
    op_size_t         wr_size;
    logic [MMX_W-1:0] wr_data;
    logic             tag_en;
    reg_addr_t        tag_addr;
    op_size_t         tag_size;
    tag_id_t          tag_id;
    logic             wb_en;
    tag_id_t          wb_tag;
    reg_addr_t        rd_addr;
    op_size_t         rd_size;
    logic [MMX_W-1:0] rd_data;
    logic             rd_pending;

    int     cmp_errors = 0;
    int     cmp_checks = 0;
    int     dir_errors = 0;
    int     dir_checks = 0;
    integer seed = 32'he8e9_0661;

    `include "tb_regfile_model.svh"

    regfile #(.NUM_MMX(8)) regfile_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_size    (wr_size),
        .wr_data    (wr_data),
        .tag_en     (tag_en),
        .tag_addr   (tag_addr),
        .tag_size   (tag_size),
        .tag_id     (tag_id),
        .wb_en      (wb_en),
        .wb_tag     (wb_tag),
        .rd_addr    (rd_addr),
        .rd_size    (rd_size),
        .rd_data    (rd_data),
        .rd_pending (rd_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One cycle of stimulus on all ports at once
    task automatic drive(input logic we, input reg_addr_t wa, input op_size_t ws,
                         input logic [MMX_W-1:0] wd, input logic te, input reg_addr_t ta,
                         input op_size_t ts, input tag_id_t ti, input logic wbe,
                         input tag_id_t wbt, input reg_addr_t ra, input op_size_t rs);
        @(posedge clk);
        wr_en    <= we;
        wr_addr  <= wa;
        wr_size  <= ws;
        wr_data  <= wd;
        tag_en   <= te;
        tag_addr <= ta;
        tag_size <= ts;
        tag_id   <= ti;
        wb_en    <= wbe;
        wb_tag   <= wbt;
        rd_addr  <= ra;
        rd_size  <= rs;
    endtask

    task automatic write_op(input reg_addr_t a, input op_size_t s, input logic [MMX_W-1:0] d);
        drive(1'b1, a, s, d, 1'b0, '0, size_8, '0, 1'b0, '0, rd_addr, rd_size);
    endtask

    task automatic reserve_op(input reg_addr_t a, input op_size_t s, input tag_id_t id);
        drive(1'b0, '0, size_8, '0, 1'b1, a, s, id, 1'b0, '0, rd_addr, rd_size);
    endtask

    task automatic retire_op(input tag_id_t tag);
        drive(1'b0, '0, size_8, '0, 1'b0, '0, size_8, '0, 1'b1, tag, rd_addr, rd_size);
    endtask

    // Reservation and writeback in the same cycle
    task automatic reserve_retire_op(input reg_addr_t a, input op_size_t s, input tag_id_t id,
                                     input tag_id_t tag);
        drive(1'b0, '0, size_8, '0, 1'b1, a, s, id, 1'b1, tag, rd_addr, rd_size);
    endtask

    task automatic read_op(input reg_addr_t a, input op_size_t s);
        drive(1'b0, '0, size_8, '0, 1'b0, '0, size_8, '0, 1'b0, '0, a, s);
    endtask

    task automatic check_read(input reg_addr_t a, input op_size_t s,
                              input logic [MMX_W-1:0] exp_d, input logic exp_p);
        read_op(a, s);
        @(negedge clk);
        dir_checks++;
        if (rd_data !== exp_d) begin
            dir_errors++;
            $display("FAIL t=%0t rd_data expected %h got %h", $time, exp_d, rd_data);
        end
        if (rd_pending !== exp_p) begin
            dir_errors++;
            $display("FAIL t=%0t rd_pending expected %b got %b", $time, exp_p, rd_pending);
        end
    endtask

    task automatic await_pending(input logic exp, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rd_pending !== exp && n < limit);
        if (rd_pending !== exp) begin
            dir_errors++;
            $display("Timeout at %0t: rd_pending did not change to %b within %0d cycles",
                     $time, exp, limit);
        end
    endtask

    // Compare against the model just before each edge and then apply what that edge captures
    initial begin : compare
        logic [MMX_W-1:0] exp_data;
        logic             exp_pend;
        forever begin
            @(posedge clk);
            #(CLK_PERIOD - 10);
            if (!rst_n) begin
                clear_model();
            end else begin
                exp_data = predict_data(rd_addr, rd_size);
                exp_pend = covers_pending(rd_addr, rd_size);
                cmp_checks++;
                if (rd_data !== exp_data) begin
                    cmp_errors++;
                    $display("FAIL t=%0t rd_data expected %h got %h", $time, exp_data, rd_data);
                end
                if (rd_pending !== exp_pend) begin
                    cmp_errors++;
                    $display("FAIL t=%0t rd_pending expected %b got %b",
                             $time, exp_pend, rd_pending);
                end
                if (wb_en) retire_tag(wb_tag);   // Clear first so a new reservation wins
                if (tag_en) reserve_tags(tag_addr, tag_size, tag_id);
                if (wr_en) mirror_write(wr_addr, wr_size, wr_data);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        rst_n    <= 1'b0;
        wr_en    <= 1'b0;
        wr_addr  <= '0;
        wr_size  <= size_8;
        wr_data  <= '0;
        tag_en   <= 1'b0;
        tag_addr <= '0;
        tag_size <= size_8;
        tag_id   <= '0;
        wb_en    <= 1'b0;
        wb_tag   <= '0;
        rd_addr  <= '0;
        rd_size  <= size_8;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int a = 0; a < 8; a++) begin
            check_read(reg_addr_t'(a), size_8, '0, 1'b0);
            check_read(reg_addr_t'(a), size_16, '0, 1'b0);
            check_read(reg_addr_t'(a), size_32, '0, 1'b0);
            check_read(reg_addr_t'(a), size_64, '0, 1'b0);
        end

        // Sized writes to ECX with don't-care upper data bits
        write_op(3'd1, size_32, 64'hFFFF_0000_89AB_CDEF);
        check_read(3'd1, size_32, 64'hFFFF_FFFF_89AB_CDEF, 1'b0);
        check_read(3'd1, size_16, 64'hFFFF_FFFF_FFFF_CDEF, 1'b0);
        check_read(3'd1, size_8, 64'hFFFF_FFFF_FFFF_FFEF, 1'b0);
        check_read(3'd5, size_8, 64'hFFFF_FFFF_FFFF_FFCD, 1'b0);
        write_op(3'd1, size_16, 64'hAAAA_AAAA_AAAA_1234);
        check_read(3'd1, size_32, 64'hFFFF_FFFF_89AB_1234, 1'b0);
        check_read(3'd1, size_16, 64'h0000_0000_0000_1234, 1'b0);
        write_op(3'd5, size_8, 64'h0000_0000_0000_5580);   // CH
        check_read(3'd5, size_8, 64'hFFFF_FFFF_FFFF_FF80, 1'b0);
        check_read(3'd1, size_8, 64'h0000_0000_0000_0034, 1'b0);
        write_op(3'd1, size_8, 64'h0000_0000_0000_007F);   // CL
        check_read(3'd1, size_16, 64'hFFFF_FFFF_FFFF_807F, 1'b0);
        check_read(3'd1, size_32, 64'hFFFF_FFFF_89AB_807F, 1'b0);
        check_read(3'd5, size_32, '0, 1'b0);

        // MMX file is separate from the general registers
        write_op(3'd1, size_64, 64'h0123_4567_89AB_CDEF);
        write_op(3'd7, size_64, 64'h8000_0000_0000_0001);
        check_read(3'd1, size_64, 64'h0123_4567_89AB_CDEF, 1'b0);
        check_read(3'd7, size_64, 64'h8000_0000_0000_0001, 1'b0);
        check_read(3'd1, size_32, 64'hFFFF_FFFF_89AB_807F, 1'b0);
        check_read(3'd7, size_32, '0, 1'b0);

        // DL pending but DH not
        reserve_op(3'd2, size_8, 7'h11);
        check_read(3'd6, size_8, '0, 1'b0);
        check_read(3'd2, size_8, '0, 1'b1);
        check_read(3'd2, size_16, '0, 1'b1);
        check_read(3'd2, size_32, '0, 1'b1);
        check_read(3'd2, size_64, '0, 1'b0);
        retire_op(7'h12);
        check_read(3'd2, size_8, '0, 1'b1);
        retire_op(7'h11);
        read_op(3'd2, size_8);
        await_pending(1'b0, 4);
        check_read(3'd2, size_32, '0, 1'b0);

        // Same-cycle reservation and matching writeback
        reserve_op(3'd3, size_32, 7'h21);
        reserve_retire_op(3'd3, size_16, 7'h22, 7'h21);
        check_read(3'd3, size_16, '0, 1'b1);
        check_read(3'd3, size_32, '0, 1'b1);
        retire_op(7'h22);
        read_op(3'd3, size_32);
        await_pending(1'b0, 4);
        reserve_op(3'd4, size_64, 7'h30);
        reserve_retire_op(3'd4, size_64, 7'h30, 7'h30);
        check_read(3'd4, size_64, '0, 1'b1);
        retire_op(7'h30);
        read_op(3'd4, size_64);
        await_pending(1'b0, 4);

        // Small tag range so writebacks hit often
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = $random(seed);
            drive(r[0], r[3:1], op_size_t'(r[5:4]), {$random(seed), $random(seed)},
                  r[6] & r[7], r[10:8], op_size_t'(r[12:11]), tag_id_t'(r[15:13]),
                  r[16], tag_id_t'(r[19:17]), r[22:20], op_size_t'(r[24:23]));
        end

        read_op(3'd0, size_32);
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", cmp_checks + dir_checks, cmp_errors + dir_errors);
        if (cmp_errors + dir_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile #(
    parameter int NUM_MMX = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_en,
    input  wire regfile_pkg::reg_addr_t   wr_addr,
    input  wire regfile_pkg::op_size_t    wr_size,
    input  wire [regfile_pkg::MMX_W-1:0]  wr_data,
    input  wire                           tag_en,
    input  wire regfile_pkg::reg_addr_t   tag_addr,
    input  wire regfile_pkg::op_size_t    tag_size,
    input  wire tag_pkg::tag_id_t         tag_id,
    input  wire                           wb_en,
    input  wire tag_pkg::tag_id_t         wb_tag,
    input  wire regfile_pkg::reg_addr_t   rd_addr,
    input  wire regfile_pkg::op_size_t    rd_size,
    output logic [regfile_pkg::MMX_W-1:0] rd_data,
    output logic                          rd_pending
);
    import regfile_pkg::*;

    logic             wr_mmx, tag_mmx;
    logic [MMX_W-1:0] gpr_rd_data, mmx_rd_data;
    logic             gpr_rd_pending, mmx_rd_pending;

    assign wr_mmx  = (wr_size == size_64);
    assign tag_mmx = (tag_size == size_64);

    gpr_bank gpr_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en && !wr_mmx),
        .wr_addr    (wr_addr),
        .wr_size    (wr_size),
        .wr_data    (wr_data[GPR_W-1:0]),
        .tag_en     (tag_en && !tag_mmx),
        .tag_addr   (tag_addr),
        .tag_size   (tag_size),
        .tag_id     (tag_id),
        .wb_en      (wb_en),      // Writeback goes to both files
        .wb_tag     (wb_tag),
        .rd_addr    (rd_addr),
        .rd_size    (rd_size),
        .rd_data    (gpr_rd_data),
        .rd_pending (gpr_rd_pending)
    );

    mmx_bank #(.NUM_MMX(NUM_MMX)) mmx_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en && wr_mmx),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .tag_en     (tag_en && tag_mmx),
        .tag_addr   (tag_addr),
        .tag_id     (tag_id),
        .wb_en      (wb_en),
        .wb_tag     (wb_tag),
        .rd_addr    (rd_addr),
        .rd_data    (mmx_rd_data),
        .rd_pending (mmx_rd_pending)
    );

    assign rd_data    = (rd_size == size_64) ? mmx_rd_data : gpr_rd_data;
    assign rd_pending = (rd_size == size_64) ? mmx_rd_pending : gpr_rd_pending;

endmodule

`default_nettype wire

// File: mmx_bank.sv
`timescale 1ns/100ps
`default_nettype none

module mmx_bank #(
    parameter int NUM_MMX = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_en,
    input  wire regfile_pkg::reg_addr_t   wr_addr,
    input  wire [regfile_pkg::MMX_W-1:0]  wr_data,
    input  wire                           tag_en,
    input  wire regfile_pkg::reg_addr_t   tag_addr,
    input  wire tag_pkg::tag_id_t         tag_id,
    input  wire                           wb_en,
    input  wire tag_pkg::tag_id_t         wb_tag,
    input  wire regfile_pkg::reg_addr_t   rd_addr,
    output logic [regfile_pkg::MMX_W-1:0] rd_data,
    output logic                          rd_pending
);
    import regfile_pkg::*;

    logic [MMX_W-1:0]   slot_dout [NUM_MMX];
    logic [NUM_MMX-1:0] slot_pend;

    for (genvar i = 0; i < NUM_MMX; i++) begin : g_slot
        mmx_slot mmx_slot_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .ld      (wr_en && wr_addr == reg_addr_t'(i)),
            .din     (wr_data),
            .tag_set (tag_en && tag_addr == reg_addr_t'(i)),
            .tag_id  (tag_id),
            .wb_en   (wb_en),
            .wb_tag  (wb_tag),
            .dout    (slot_dout[i]),
            .pending (slot_pend[i])
        );
    end

    // Addresses past NUM_MMX read as zero
    always_comb begin
        rd_data    = '0;
        rd_pending = 1'b0;
        for (int k = 0; k < NUM_MMX; k++) begin
            if (rd_addr == reg_addr_t'(k)) begin
                rd_data    = slot_dout[k];
                rd_pending = slot_pend[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: mmx_slot.sv
`timescale 1ns/100ps
`default_nettype none

module mmx_slot (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           ld,
    input  wire [regfile_pkg::MMX_W-1:0]  din,
    input  wire                           tag_set,
    input  wire tag_pkg::tag_id_t         tag_id,
    input  wire                           wb_en,
    input  wire tag_pkg::tag_id_t         wb_tag,
    output logic [regfile_pkg::MMX_W-1:0] dout,
    output logic                          pending
);
    import tag_pkg::*;

    tag_id_t id_q;
    logic    valid_q;
    logic    wb_hit;

    assign wb_hit = wb_en && valid_q && (id_q == wb_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout    <= '0;
            id_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            if (ld) dout <= din;
            if (tag_set) begin
                valid_q <= 1'b1;
                id_q    <= tag_id;
            end else if (wb_hit) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign pending = valid_q;

endmodule

`default_nettype wire

// File: gpr_bank.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_bank (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_en,
    input  wire regfile_pkg::reg_addr_t   wr_addr,
    input  wire regfile_pkg::op_size_t    wr_size,
    input  wire [regfile_pkg::GPR_W-1:0]  wr_data,
    input  wire                           tag_en,
    input  wire regfile_pkg::reg_addr_t   tag_addr,
    input  wire regfile_pkg::op_size_t    tag_size,
    input  wire tag_pkg::tag_id_t         tag_id,
    input  wire                           wb_en,
    input  wire tag_pkg::tag_id_t         wb_tag,
    input  wire regfile_pkg::reg_addr_t   rd_addr,
    input  wire regfile_pkg::op_size_t    rd_size,
    output logic [regfile_pkg::MMX_W-1:0] rd_data,
    output logic                          rd_pending
);
    import regfile_pkg::*;
    import tag_pkg::*;

    // Sections touched by an access of the given size
    function automatic sect_mask_t sect_of(reg_addr_t addr, op_size_t size);
        sect_mask_t m;
        m = '0;
        case (size)
            size_32: m = '1;
            size_16: begin
                m[SECT_H] = 1'b1;
                m[SECT_L] = 1'b1;
            end
            size_8: begin
                if (addr[2]) m[SECT_H] = 1'b1;
                else m[SECT_L] = 1'b1;
            end
            default: m = '0;
        endcase
        return m;
    endfunction

    // Byte addresses 4-7 name the high byte of registers 0-3
    function automatic reg_addr_t slot_of(reg_addr_t addr, op_size_t size);
        return (size == size_8) ? {1'b0, addr[1:0]} : addr;
    endfunction

    logic [GPR_W-1:0]  slot_dout [NUM_GPR];
    sect_mask_t        slot_pend [NUM_GPR];
    reg_addr_t         wr_slot, tag_slot, rd_slot;
    sect_mask_t        wr_mask, tag_mask, rd_mask;
    logic              wr_hi;
    logic [GPR_W-1:0]  wr_steer;
    logic [GPR_W-1:0]  rd_word;
    logic [BYTE_W-1:0] rd_byte;

    assign wr_slot  = slot_of(wr_addr, wr_size);
    assign wr_mask  = sect_of(wr_addr, wr_size);
    assign tag_slot = slot_of(tag_addr, tag_size);
    assign tag_mask = sect_of(tag_addr, tag_size);

    // AH..BH writes carry their byte in the low lane
    assign wr_hi    = (wr_size == size_8) && wr_addr[2];
    assign wr_steer = {wr_data[GPR_W-1:2*BYTE_W],
                       wr_hi ? wr_data[BYTE_W-1:0] : wr_data[2*BYTE_W-1:BYTE_W],
                       wr_data[BYTE_W-1:0]};

    for (genvar i = 0; i < NUM_GPR; i++) begin : g_slot
        gpr_slot gpr_slot_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .ld_mask  ((wr_en && wr_slot == reg_addr_t'(i)) ? wr_mask : '0),
            .din      (wr_steer),
            .tag_mask ((tag_en && tag_slot == reg_addr_t'(i)) ? tag_mask : '0),
            .tag_id   (tag_id),
            .wb_en    (wb_en),
            .wb_tag   (wb_tag),
            .dout     (slot_dout[i]),
            .pending  (slot_pend[i])
        );
    end

    assign rd_slot    = slot_of(rd_addr, rd_size);
    assign rd_mask    = sect_of(rd_addr, rd_size);
    assign rd_word    = slot_dout[rd_slot];
    assign rd_byte    = rd_addr[2] ? rd_word[2*BYTE_W-1:BYTE_W] : rd_word[BYTE_W-1:0];
    assign rd_pending = |(slot_pend[rd_slot] & rd_mask);

    always_comb begin
        case (rd_size)
            size_8:  rd_data = {{(MMX_W-BYTE_W){rd_byte[BYTE_W-1]}}, rd_byte};
            size_16: rd_data = {{(MMX_W-2*BYTE_W){rd_word[2*BYTE_W-1]}}, rd_word[2*BYTE_W-1:0]};
            size_32: rd_data = {{(MMX_W-GPR_W){rd_word[GPR_W-1]}}, rd_word};
            default: rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: gpr_slot.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_slot (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire tag_pkg::sect_mask_t     ld_mask,
    input  wire [regfile_pkg::GPR_W-1:0] din,
    input  wire tag_pkg::sect_mask_t     tag_mask,
    input  wire tag_pkg::tag_id_t        tag_id,
    input  wire                          wb_en,
    input  wire tag_pkg::tag_id_t        wb_tag,
    output logic [regfile_pkg::GPR_W-1:0] dout,
    output tag_pkg::sect_mask_t          pending
);
    import regfile_pkg::*;
    import tag_pkg::*;

    logic [E_W-1:0]    e_q;
    logic [BYTE_W-1:0] h_q;
    logic [BYTE_W-1:0] l_q;
    tag_id_t           id_q [3];
    sect_mask_t        valid_q;
    sect_mask_t        wb_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_q <= '0;
            h_q <= '0;
            l_q <= '0;
        end else begin
            if (ld_mask[SECT_E]) e_q <= din[GPR_W-1:2*BYTE_W];
            if (ld_mask[SECT_H]) h_q <= din[2*BYTE_W-1:BYTE_W];
            if (ld_mask[SECT_L]) l_q <= din[BYTE_W-1:0];
        end
    end

    // Writeback match per section
    always_comb begin
        for (int s = 0; s < 3; s++) begin
            wb_hit[s] = wb_en && valid_q[s] && (id_q[s] == wb_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            for (int s = 0; s < 3; s++) begin
                id_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < 3; s++) begin
                if (tag_mask[s]) begin   // New reservation beats a same-cycle writeback
                    valid_q[s] <= 1'b1;
                    id_q[s]    <= tag_id;
                end else if (wb_hit[s]) begin
                    valid_q[s] <= 1'b0;
                end
            end
        end
    end

    assign dout    = {e_q, h_q, l_q};
    assign pending = valid_q;

endmodule

`default_nettype wire

// File: tag_pkg.sv
`default_nettype none

package tag_pkg;

    localparam int TAG_W = 7;

    // Id of the in-flight instruction that owns a register section
    typedef logic [TAG_W-1:0] tag_id_t;

    // One bit per general register section with E H L from the top down
    typedef logic [2:0] sect_mask_t;

    localparam int SECT_E = 2;
    localparam int SECT_H = 1;
    localparam int SECT_L = 0;

endpackage

`default_nettype wire

// File: regfile_pkg.sv
`default_nettype none

package regfile_pkg;

    // Operand size of a register access
    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2,
        size_64 = 2'd3   // MMX file
    } op_size_t;

    // Register number from 0 to 7
    typedef logic [2:0] reg_addr_t;

    localparam int GPR_W = 32;
    localparam int MMX_W = 64;   // Also width of the data ports

    // Fixed at eight; byte addresses 4-7 alias the high bytes of 0-3
    localparam int NUM_GPR = 8;

    // Section widths of a general register
    localparam int E_W = 16;
    localparam int BYTE_W = 8;

endpackage

`default_nettype wire
